// File: source/coproc_config.svh
// Sizing of the coprocessor buffers and the FP register file
// Depths below 1 are not supported; register count must stay 32 for 5-bit specifiers
`ifndef COPROC_CONFIG_SVH
`define COPROC_CONFIG_SVH

// Request and response buffer depths
`define COPROC_REQ_DEPTH 2
`define COPROC_RSP_DEPTH 2

// Architectural FP registers
`define COPROC_NUM_FPR 32

`endif

// File: source/coproc_isa_pkg.sv
// RV32F OP-FP encodings for the supported subset only
// Single precision (fmt = 00) is the only format decoded
package coproc_isa_pkg;

  // Operation selected by the decoder
  typedef enum logic [3:0] {
    SGNJ    = 4'd0,
    SGNJN   = 4'd1,
    SGNJX   = 4'd2,
    MV_W_X  = 4'd3,
    MV_X_W  = 4'd4,
    FEQ     = 4'd5,
    FLT     = 4'd6,
    FLE     = 4'd7,
    FMIN    = 4'd8,
    FMAX    = 4'd9,
    ILLEGAL = 4'd15
  } fp_op_e;

  localparam logic [6:0] OPC_OP_FP = 7'b1010011;

  // Funct7 groups, single-precision format
  localparam logic [6:0] F7_SGNJ   = 7'b0010000;
  localparam logic [6:0] F7_MINMAX = 7'b0010100;
  localparam logic [6:0] F7_CMP    = 7'b1010000;
  localparam logic [6:0] F7_MV_X_W = 7'b1110000;
  localparam logic [6:0] F7_MV_W_X = 7'b1111000;

  // Decoder result
  typedef struct packed {
    fp_op_e op;
    logic   rd_is_fp;
  } fp_dec_t;

endpackage

// File: source/coproc_bus_pkg.sv
// Payloads of the offload request and response channels
// Only rs1 is carried from the core; no other integer operand is used
package coproc_bus_pkg;

  // Offloaded instruction with its integer source
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] hart_id;
  } coproc_req_t;

  // One response per instruction, in order
  typedef struct packed {
    logic [31:0] data;
    logic [4:0]  rd;
    logic [31:0] hart_id;
    logic        error;
  } coproc_rsp_t;

endpackage

// File: source/issue_if.sv
// Decoder to execute handshake; transfer when valid and ready are high
`timescale 1ns/1ns

interface issue_if import coproc_isa_pkg::*; ();

  logic        valid;
  logic        ready;
  fp_op_e      op;
  logic [31:0] opa;
  logic [31:0] opb;
  logic [4:0]  rd;
  logic        rd_is_fp;
  logic [31:0] hart_id;

  modport issuer (
    output valid, op, opa, opb, rd, rd_is_fp, hart_id,
    input  ready
  );

  modport executor (
    input  valid, op, opa, opb, rd, rd_is_fp, hart_id,
    output ready
  );

endinterface

// File: source/stream_buffer.sv
// Fall-through FIFO; an empty buffer forwards its input in the same cycle
// ready_o is the not-full flag and does not depend on ready_i
`timescale 1ns/1ns

module stream_buffer #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T               mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [CW-1:0]  count;
  logic           empty;
  logic           push;
  logic           pop;

  assign empty   = (count == '0);
  assign ready_o = (count != CW'(DEPTH));
  assign valid_o = !empty || valid_i;
  assign data_o  = empty ? data_i : mem[rd_ptr];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (!(empty && push && pop)) begin
      // Bypass case above leaves the state untouched
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !(empty && pop)) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

// File: source/fp_decoder.sv
// Combinational decode of the request buffer head
// Anything outside the supported OP-FP subset is issued as ILLEGAL
`timescale 1ns/1ns

module fp_decoder import coproc_isa_pkg::*, coproc_bus_pkg::*; (
  input  coproc_req_t   head_i,
  input  logic          head_valid_i,
  output logic          head_pop_o,
  output logic [4:0]    raddr_a_o,
  output logic [4:0]    raddr_b_o,
  input  logic [31:0]   rdata_a_i,
  input  logic [31:0]   rdata_b_i,
  input  logic          fwd_valid_i,
  input  logic [4:0]    fwd_rd_i,
  input  logic          fwd_rd_is_fp_i,
  input  logic [31:0]   fwd_data_i,
  issue_if.issuer       issue
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  fp_dec_t     dec;
  logic        fwd_a;
  logic        fwd_b;
  logic [31:0] fpr_a;
  logic [31:0] fpr_b;

  assign opcode = head_i.instr[6:0];
  assign funct3 = head_i.instr[14:12];
  assign rs1    = head_i.instr[19:15];
  assign rs2    = head_i.instr[24:20];
  assign funct7 = head_i.instr[31:25];

  always_comb begin
    dec = '{op: ILLEGAL, rd_is_fp: 1'b0};
    if (opcode == OPC_OP_FP) begin
      unique case (funct7)
        F7_SGNJ: begin
          if (funct3 == 3'b000) dec = '{op: SGNJ, rd_is_fp: 1'b1};
          if (funct3 == 3'b001) dec = '{op: SGNJN, rd_is_fp: 1'b1};
          if (funct3 == 3'b010) dec = '{op: SGNJX, rd_is_fp: 1'b1};
        end
        F7_MINMAX: begin
          if (funct3 == 3'b000) dec = '{op: FMIN, rd_is_fp: 1'b1};
          if (funct3 == 3'b001) dec = '{op: FMAX, rd_is_fp: 1'b1};
        end
        F7_CMP: begin
          if (funct3 == 3'b010) dec = '{op: FEQ, rd_is_fp: 1'b0};
          if (funct3 == 3'b001) dec = '{op: FLT, rd_is_fp: 1'b0};
          if (funct3 == 3'b000) dec = '{op: FLE, rd_is_fp: 1'b0};
        end
        // fclass shares this funct7 with funct3 001 and stays illegal
        F7_MV_X_W: begin
          if (funct3 == 3'b000 && rs2 == 5'd0) dec = '{op: MV_X_W, rd_is_fp: 1'b0};
        end
        F7_MV_W_X: begin
          if (funct3 == 3'b000 && rs2 == 5'd0) dec = '{op: MV_W_X, rd_is_fp: 1'b1};
        end
        default: ;
      endcase
    end
  end

  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  // Bypass the result still waiting in execute
  assign fwd_a = fwd_valid_i && fwd_rd_is_fp_i && (fwd_rd_i == rs1);
  assign fwd_b = fwd_valid_i && fwd_rd_is_fp_i && (fwd_rd_i == rs2);
  assign fpr_a = fwd_a ? fwd_data_i : rdata_a_i;
  assign fpr_b = fwd_b ? fwd_data_i : rdata_b_i;

  assign issue.valid    = head_valid_i;
  assign issue.op       = dec.op;
  assign issue.opa      = (dec.op == MV_W_X) ? head_i.rs1 : fpr_a;
  assign issue.opb      = fpr_b;
  assign issue.rd       = head_i.instr[11:7];
  assign issue.rd_is_fp = dec.rd_is_fp;
  assign issue.hart_id  = head_i.hart_id;
  assign head_pop_o     = head_valid_i && issue.ready;

endmodule

// File: source/fp_regfile.sv
// FP register file, no reset; contents are undefined until written
// Two asynchronous reads, one synchronous write
`timescale 1ns/1ns
`include "coproc_config.svh"

module fp_regfile (
  input  logic        clk_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);

  logic [31:0] regs [`COPROC_NUM_FPR];

  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

  // f0 is an ordinary register, unlike x0
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

// File: source/fp_execute.sv
// Single-cycle execute with one result register
// Compares are sign-magnitude with +0 == -0; NaNs are not special-cased
`timescale 1ns/1ns

module fp_execute import coproc_isa_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  issue_if.executor   issue,
  output logic        res_valid_o,
  output logic [31:0] res_data_o,
  output logic [4:0]  res_rd_o,
  output logic        res_rd_is_fp_o,
  output logic [31:0] res_hart_id_o,
  output logic        res_error_o,
  input  logic        res_ready_i
);

  logic        a_sign;
  logic        b_sign;
  logic [30:0] a_mag;
  logic [30:0] b_mag;
  logic        both_zero;
  logic        equal;
  logic        less;
  logic [31:0] result;
  logic        fire;

  assign a_sign    = issue.opa[31];
  assign b_sign    = issue.opb[31];
  assign a_mag     = issue.opa[30:0];
  assign b_mag     = issue.opb[30:0];
  assign both_zero = (a_mag == '0) && (b_mag == '0);
  assign equal     = both_zero || (issue.opa == issue.opb);

  // Shared by compares and min/max
  always_comb begin
    if (both_zero) begin
      less = 1'b0;
    end else if (a_sign != b_sign) begin
      less = a_sign;
    end else if (a_sign) begin
      less = a_mag > b_mag;
    end else begin
      less = a_mag < b_mag;
    end
  end

  always_comb begin
    unique case (issue.op)
      SGNJ:   result = {b_sign, a_mag};
      SGNJN:  result = {~b_sign, a_mag};
      SGNJX:  result = {a_sign ^ b_sign, a_mag};
      MV_W_X: result = issue.opa;
      MV_X_W: result = issue.opa;
      FEQ:    result = {31'd0, equal};
      FLT:    result = {31'd0, less};
      FLE:    result = {31'd0, less | equal};
      // Ties keep rs1
      FMIN:   result = (less || equal) ? issue.opa : issue.opb;
      FMAX:   result = less ? issue.opb : issue.opa;
      default: result = '0;
    endcase
  end

  // Accept when empty or when the held result drains this cycle
  assign issue.ready = !res_valid_o || res_ready_i;
  assign fire        = issue.valid && issue.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_valid_o <= 1'b0;
    end else if (fire) begin
      res_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      res_data_o     <= result;
      res_rd_o       <= issue.rd;
      res_rd_is_fp_o <= issue.rd_is_fp;
      res_hart_id_o  <= issue.hart_id;
      res_error_o    <= (issue.op == ILLEGAL);
    end
  end

endmodule

// File: source/fp_writeback.sv
// Register write and response push on the same accepted result
// Illegal results are answered but never written
`timescale 1ns/1ns
`include "coproc_config.svh"

module fp_writeback import coproc_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        res_valid_i,
  input  logic [31:0] res_data_i,
  input  logic [4:0]  res_rd_i,
  input  logic        res_rd_is_fp_i,
  input  logic [31:0] res_hart_id_i,
  input  logic        res_error_i,
  output logic        res_ready_o,
  output logic        fpr_we_o,
  output logic [4:0]  fpr_waddr_o,
  output logic [31:0] fpr_wdata_o,
  output logic        c_p_valid_o,
  input  logic        c_p_ready_i,
  output logic [31:0] c_p_data_o,
  output logic [4:0]  c_p_rd_o,
  output logic [31:0] c_p_hart_id_o,
  output logic        c_p_error_o
);

  coproc_rsp_t rsp_push;
  coproc_rsp_t rsp_head;

  assign fpr_we_o    = res_valid_i && res_ready_o && res_rd_is_fp_i && !res_error_i;
  assign fpr_waddr_o = res_rd_i;
  assign fpr_wdata_o = res_data_i;

  // Execute already zeroes data for illegal ops
  assign rsp_push = '{data: res_data_i, rd: res_rd_i, hart_id: res_hart_id_i,
                      error: res_error_i};

  stream_buffer #(
    .T     (coproc_rsp_t),
    .DEPTH (`COPROC_RSP_DEPTH)
  ) u_rsp_buffer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (rsp_push),
    .valid_i (res_valid_i),
    .ready_o (res_ready_o),
    .data_o  (rsp_head),
    .valid_o (c_p_valid_o),
    .ready_i (c_p_ready_i)
  );

  assign c_p_data_o    = rsp_head.data;
  assign c_p_rd_o      = rsp_head.rd;
  assign c_p_hart_id_o = rsp_head.hart_id;
  assign c_p_error_o   = rsp_head.error;

endmodule

// File: source/fp_coproc.sv
// Single-precision FP coprocessor for sign-injection, moves, compares, min/max
// In-order, one response per request; no rounding, CSRs, loads or stores
`timescale 1ns/1ns
`include "coproc_config.svh"

module fp_coproc import coproc_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        c_q_valid_i,
  output logic        c_q_ready_o,
  input  logic [31:0] c_q_instr_i,
  input  logic [31:0] c_q_rs1_i,
  input  logic [31:0] c_q_hart_id_i,
  output logic        c_p_valid_o,
  input  logic        c_p_ready_i,
  output logic [31:0] c_p_data_o,
  output logic [4:0]  c_p_rd_o,
  output logic [31:0] c_p_hart_id_o,
  output logic        c_p_error_o
);

  coproc_req_t req_push;
  coproc_req_t req_head;
  logic        head_valid;
  logic        head_pop;
  logic [4:0]  raddr_a;
  logic [4:0]  raddr_b;
  logic [31:0] rdata_a;
  logic [31:0] rdata_b;
  logic        res_valid;
  logic [31:0] res_data;
  logic [4:0]  res_rd;
  logic        res_rd_is_fp;
  logic [31:0] res_hart_id;
  logic        res_error;
  logic        res_ready;
  logic        fpr_we;
  logic [4:0]  fpr_waddr;
  logic [31:0] fpr_wdata;

  issue_if issue ();

  assign req_push = '{instr: c_q_instr_i, rs1: c_q_rs1_i, hart_id: c_q_hart_id_i};

  stream_buffer #(
    .T     (coproc_req_t),
    .DEPTH (`COPROC_REQ_DEPTH)
  ) u_req_buffer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (req_push),
    .valid_i (c_q_valid_i),
    .ready_o (c_q_ready_o),
    .data_o  (req_head),
    .valid_o (head_valid),
    .ready_i (head_pop)
  );

  fp_decoder u_decoder (
    .head_i         (req_head),
    .head_valid_i   (head_valid),
    .head_pop_o     (head_pop),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .fwd_valid_i    (res_valid),
    .fwd_rd_i       (res_rd),
    .fwd_rd_is_fp_i (res_rd_is_fp),
    .fwd_data_i     (res_data),
    .issue          (issue.issuer)
  );

  fp_regfile u_regfile (
    .clk_i     (clk_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (fpr_we),
    .waddr_i   (fpr_waddr),
    .wdata_i   (fpr_wdata)
  );

  // Held result doubles as the forwarding source
  fp_execute u_execute (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue          (issue.executor),
    .res_valid_o    (res_valid),
    .res_data_o     (res_data),
    .res_rd_o       (res_rd),
    .res_rd_is_fp_o (res_rd_is_fp),
    .res_hart_id_o  (res_hart_id),
    .res_error_o    (res_error),
    .res_ready_i    (res_ready)
  );

  fp_writeback u_writeback (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .res_valid_i    (res_valid),
    .res_data_i     (res_data),
    .res_rd_i       (res_rd),
    .res_rd_is_fp_i (res_rd_is_fp),
    .res_hart_id_i  (res_hart_id),
    .res_error_i    (res_error),
    .res_ready_o    (res_ready),
    .fpr_we_o       (fpr_we),
    .fpr_waddr_o    (fpr_waddr),
    .fpr_wdata_o    (fpr_wdata),
    .c_p_valid_o    (c_p_valid_o),
    .c_p_ready_i    (c_p_ready_i),
    .c_p_data_o     (c_p_data_o),
    .c_p_rd_o       (c_p_rd_o),
    .c_p_hart_id_o  (c_p_hart_id_o),
    .c_p_error_o    (c_p_error_o)
  );

endmodule

// File: dv/fp_coproc_tb.sv
// Testbench for fp_coproc; expected responses come from an in-order model
// Model registers are defined only after the first test loads all 32 of them
`timescale 1ns/1ns

module fp_coproc_tb import coproc_bus_pkg::*; ();

  localparam int N_SGN  = 24;
  localparam int N_CMP  = 40;
  localparam int N_DEP  = 20;
  localparam int N_ILL  = 8;
  localparam int N_RND  = 60;
  localparam int N_REQ  = 64 + 2 * N_SGN + 3 * N_CMP + N_DEP + 2 * N_ILL + N_RND;
  localparam int TIMEOUT_CYCLES = N_REQ * 20 + 200;

  logic        clk_i;
  logic        rst_i;
  logic        c_q_valid_i;
  logic        c_q_ready_o;
  logic [31:0] c_q_instr_i;
  logic [31:0] c_q_rs1_i;
  logic [31:0] c_q_hart_id_i;
  logic        c_p_valid_o;
  logic        c_p_ready_i;
  logic [31:0] c_p_data_o;
  logic [4:0]  c_p_rd_o;
  logic [31:0] c_p_hart_id_o;
  logic        c_p_error_o;

  int          seed = 32'haa66_1472;
  int          ready_seed = 32'haa66_1472;
  logic        gap_mode = 1'b0;
  int          errors = 0;
  int          sent = 0;
  int          rcvd = 0;
  int          stalls = 0;
  logic [31:0] model_fpr [32];
  coproc_rsp_t exp_q [$];

  fp_coproc UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand_u32();
    rand_u32 = $random(seed);
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    encode = {f7, rs2, rs1, f3, rd, 7'b1010011};
  endfunction

  // Kinds 0 to 9 are fsgnj, fsgnjn, fsgnjx, fmv.w.x, fmv.x.w, feq, flt, fle, fmin, fmax
  function automatic logic [31:0] op_instr(input int unsigned k, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
    case (k)
      0: op_instr = encode(7'b0010000, rs2, rs1, 3'b000, rd);
      1: op_instr = encode(7'b0010000, rs2, rs1, 3'b001, rd);
      2: op_instr = encode(7'b0010000, rs2, rs1, 3'b010, rd);
      3: op_instr = encode(7'b1111000, 5'd0, rs1, 3'b000, rd);
      4: op_instr = encode(7'b1110000, 5'd0, rs1, 3'b000, rd);
      5: op_instr = encode(7'b1010000, rs2, rs1, 3'b010, rd);
      6: op_instr = encode(7'b1010000, rs2, rs1, 3'b001, rd);
      7: op_instr = encode(7'b1010000, rs2, rs1, 3'b000, rd);
      8: op_instr = encode(7'b0010100, rs2, rs1, 3'b000, rd);
      default: op_instr = encode(7'b0010100, rs2, rs1, 3'b001, rd);
    endcase
  endfunction

  // fclass, fadd, bad funct3, fmv.x.w with rs2 set, integer opcode, double format
  function automatic logic [31:0] illegal_instr(input int unsigned k, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
    case (k)
      0: illegal_instr = encode(7'b1110000, 5'd0, rs1, 3'b001, rd);
      1: illegal_instr = encode(7'b0000000, rs2, rs1, 3'b000, rd);
      2: illegal_instr = encode(7'b0010000, rs2, rs1, 3'b011, rd);
      3: illegal_instr = encode(7'b1110000, 5'd1, rs1, 3'b000, rd);
      4: illegal_instr = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      5: illegal_instr = encode(7'b0010001, rs2, rs1, 3'b000, rd);
      6: illegal_instr = encode(7'b1010000, rs2, rs1, 3'b011, rd);
      default: illegal_instr = encode(7'b0010100, rs2, rs1, 3'b010, rd);
    endcase
  endfunction

  // Signed ordering key; +0 and -0 map to the same key
  function automatic int sm_key(input logic [31:0] v);
    int mag;
    mag = int'({1'b0, v[30:0]});
    sm_key = v[31] ? -mag : mag;
  endfunction

  function automatic coproc_rsp_t predict_rsp(input coproc_req_t req);
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic        is_fp;
    logic        legal;
    int          ka;
    int          kb;
    rs1   = req.instr[19:15];
    rs2   = req.instr[24:20];
    rd    = req.instr[11:7];
    a     = model_fpr[rs1];
    b     = model_fpr[rs2];
    ka    = sm_key(a);
    kb    = sm_key(b);
    val   = '0;
    is_fp = 1'b0;
    legal = (req.instr[6:0] == 7'b1010011);
    if (legal) begin
      case ({req.instr[31:25], req.instr[14:12]})
        10'b0010000_000: begin
          val   = {b[31], a[30:0]};
          is_fp = 1'b1;
        end
        10'b0010000_001: begin
          val   = {!b[31], a[30:0]};
          is_fp = 1'b1;
        end
        10'b0010000_010: begin
          val   = {a[31] ^ b[31], a[30:0]};
          is_fp = 1'b1;
        end
        10'b1111000_000: begin
          val   = req.rs1;
          is_fp = 1'b1;
          legal = (rs2 == 5'd0);
        end
        10'b1110000_000: begin
          val   = a;
          legal = (rs2 == 5'd0);
        end
        10'b1010000_010: val = {31'd0, ka == kb};
        10'b1010000_001: val = {31'd0, ka < kb};
        10'b1010000_000: val = {31'd0, ka <= kb};
        10'b0010100_000: begin
          val   = (ka <= kb) ? a : b;
          is_fp = 1'b1;
        end
        10'b0010100_001: begin
          val   = (kb > ka) ? b : a;
          is_fp = 1'b1;
        end
        default: legal = 1'b0;
      endcase
    end
    if (legal && is_fp) begin
      model_fpr[rd] = val;
    end
    predict_rsp = '{data: legal ? val : 32'd0, rd: rd, hart_id: req.hart_id, error: !legal};
  endfunction

  task automatic check_rsp(input coproc_rsp_t got, input coproc_rsp_t exp);
    if (got.data !== exp.data) begin
      $display("MISMATCH c_p_data_o: expected %h got %h (response %0d)", exp.data, got.data, rcvd);
      errors++;
    end
    if (got.rd !== exp.rd) begin
      $display("MISMATCH c_p_rd_o: expected %h got %h (response %0d)", exp.rd, got.rd, rcvd);
      errors++;
    end
    if (got.hart_id !== exp.hart_id) begin
      $display("MISMATCH c_p_hart_id_o: expected %h got %h (response %0d)",
               exp.hart_id, got.hart_id, rcvd);
      errors++;
    end
    if (got.error !== exp.error) begin
      $display("MISMATCH c_p_error_o: expected %h got %h (response %0d)",
               exp.error, got.error, rcvd);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the transfer edge
  task automatic send_req(input logic [31:0] instr, input logic [31:0] rs1_val);
    coproc_req_t req;
    req = '{instr: instr, rs1: rs1_val, hart_id: rand_u32()};
    c_q_valid_i   = 1'b1;
    c_q_instr_i   = req.instr;
    c_q_rs1_i     = req.rs1;
    c_q_hart_id_i = req.hart_id;
    @(negedge clk_i);
    while (!c_q_ready_o) begin
      stalls++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    c_q_valid_i = 1'b0;
    exp_q.push_back(predict_rsp(req));
    sent++;
  endtask

  task automatic idle_cycles(input int unsigned n);
    if (n > 0) begin
      repeat (n) @(posedge clk_i);
      #1;
    end
  endtask

  task automatic load_fpr(input logic [4:0] r, input logic [31:0] v);
    send_req(op_instr(3, r, 5'd0, 5'd0), v);
  endtask

  task automatic read_fpr(input logic [4:0] r);
    send_req(op_instr(4, 5'(rand_below(32)), r, 5'd0), rand_u32());
  endtask

  // Response ready is mostly low while gap_mode is set so both buffers fill
  initial begin
    c_p_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      c_p_ready_i = gap_mode ? (($random(ready_seed) & 3) == 0) : 1'b1;
    end
  end

  // Outputs sampled at the falling edge, ahead of the transfer edge
  initial begin
    coproc_rsp_t got;
    forever begin
      @(negedge clk_i);
      if (!rst_i && c_p_valid_o && c_p_ready_i) begin
        got = '{data: c_p_data_o, rd: c_p_rd_o, hart_id: c_p_hart_id_o, error: c_p_error_o};
        if (exp_q.size() == 0) begin
          $display("ERROR: response %0d arrived with no request outstanding", rcvd);
          errors++;
        end else begin
          check_rsp(got, exp_q.pop_front());
        end
        rcvd++;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("ERROR: timeout, %0d of %0d responses never arrived", sent - rcvd, sent);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rd;
    logic [4:0]  prev;
    logic [31:0] va;
    logic [31:0] vb;
    rst_i         = 1'b1;
    c_q_valid_i   = 1'b0;
    c_q_instr_i   = '0;
    c_q_rs1_i     = '0;
    c_q_hart_id_i = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Idle state right after reset
    check_flag("c_p_valid_o", c_p_valid_o, 1'b0);
    check_flag("c_q_ready_o", c_q_ready_o, 1'b1);

    // Load every register, then read each one back
    for (int i = 0; i < 32; i++) load_fpr(5'(i), rand_u32());
    for (int i = 0; i < 32; i++) read_fpr(5'(i));

    // Sign injection checked through a read back
    for (int i = 0; i < N_SGN; i++) begin
      rd = 5'(rand_below(32));
      send_req(op_instr(rand_below(3), rd, 5'(rand_below(32)), 5'(rand_below(32))), 0);
      read_fpr(rd);
    end

    // Compares and min/max with zeros and equal pairs mixed in
    for (int i = 0; i < N_CMP; i++) begin
      ra = 5'(rand_below(32));
      rb = 5'((ra + 1 + rand_below(31)) % 32);
      va = rand_u32();
      vb = rand_u32();
      case (rand_below(5))
        0: vb = va;
        1: begin va = 32'h0000_0000; vb = 32'h8000_0000; end
        2: vb = {~va[31], va[30:0]};
        3: vb = {va[31], va[30:0] ^ 31'd1};
        default: ;
      endcase
      load_fpr(ra, va);
      load_fpr(rb, vb);
      send_req(op_instr(5 + rand_below(5), 5'(rand_below(32)), ra, rb), 0);
    end

    // Dependent chain where each source is the previous destination
    prev = 5'(rand_below(32));
    for (int i = 0; i < N_DEP; i++) begin
      rd = 5'(rand_below(32));
      send_req(op_instr((i % 2 == 0) ? rand_below(3) : 8 + rand_below(2), rd, prev,
                        (rand_below(2) == 0) ? prev : 5'(rand_below(32))), 0);
      prev = rd;
    end

    // Illegal encodings leave the destination untouched
    for (int i = 0; i < N_ILL; i++) begin
      rd = 5'(rand_below(32));
      send_req(illegal_instr(i, rd, 5'(rand_below(32)), 5'(rand_below(32))), rand_u32());
      read_fpr(rd);
    end

    // Random mix under back-pressure on both channels
    gap_mode = 1'b1;
    for (int i = 0; i < N_RND; i++) begin
      idle_cycles(rand_below(3));
      send_req(op_instr(rand_below(10), 5'(rand_below(32)), 5'(rand_below(32)),
                        5'(rand_below(32))), rand_u32());
    end
    gap_mode = 1'b0;

    while (rcvd < sent) @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    if (stalls == 0) begin
      $display("ERROR: the request channel never saw back-pressure");
      errors++;
    end
    $display("errors: %0d, requests: %0d, responses: %0d", errors, sent, rcvd);
    if (errors == 0 && rcvd == sent) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+source
source/coproc_isa_pkg.sv
source/coproc_bus_pkg.sv
source/issue_if.sv
source/stream_buffer.sv
source/fp_decoder.sv
source/fp_regfile.sv
source/fp_execute.sv
source/fp_writeback.sv
source/fp_coproc.sv
dv/fp_coproc_tb.sv

// File: Makefile
# Verilator build and run for the FP coprocessor testbench
VERILATOR ?= verilator
TOP       ?= fp_coproc_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_STR  ?= SIMULATION PASSED

SRCS := $(wildcard source/*.sv source/*.svh dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -q "$(PASS_STR)" $(LOG) && echo "check: pass" || \
	  (echo "check: fail, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
